//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// main memory array, 64-bit lines
`define MEM_64BIT_LINES 64
`define MEM_SIZE_IN_BYTES (`MEM_64BIT_LINES * 8)

// tags 1..15 are real
// tag 0 means no tag on the bus
`define NUM_MEM_TAGS 15

// cycles from response to earliest data return
`define MEM_LATENCY_IN_CYCLES 6

// request queue in front of the issue unit
`define REQ_FIFO_DEPTH 4

// completion queue, sized for every tag in flight
`define CPL_FIFO_DEPTH 16

`endif

//--- mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////////////////////////
	// memory bus
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		bus_none  = 2'b00,
		bus_load  = 2'b01,
		bus_store = 2'b10
	} bus_command_t;

	////////////////////////////////////////////////////////////
	// client side
	////////////////////////////////////////////////////////////

	// one load or store from the client
	typedef struct packed {
		bus_command_t cmd;
		logic [7:0]   id;
		logic [63:0]  addr;
		logic [63:0]  data;
	} mem_req_t;

	// accepted load, issue unit to tag table
	typedef struct packed {
		logic       valid;
		logic [3:0] tag;
		logic [7:0] id;
	} mem_issue_t;

	// returned load data for the client
	typedef struct packed {
		logic [7:0]  id;
		logic [63:0] data;
	} mem_cpl_t;

endpackage

//--- mem_fifo.sv
`timescale 1ns/10ps

module mem_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       push,
	input  payload_t                   push_data,
	input  logic                       pop,
	output payload_t                   head,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t         slots [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;

	assign head  = slots[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == DEPTH);

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (push)
			slots[wr_ptr] <= push_data;
	end

	// callers must look at full and empty first
	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- mem.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem (
	input  logic                  clock,
	input  logic                  rst_n,
	input  mem_pkg::bus_command_t proc2mem_command,
	input  logic [63:0]           proc2mem_addr,
	input  logic [63:0]           proc2mem_data,
	output logic [3:0]            mem2proc_response,
	output logic [3:0]            mem2proc_tag,
	output logic [63:0]           mem2proc_data
);
	import mem_pkg::*;

	localparam int LINE_W = $clog2(`MEM_64BIT_LINES);
	localparam int CNT_W  = $clog2(`MEM_LATENCY_IN_CYCLES + 1);

	logic [63:0]      unified_memory  [`MEM_64BIT_LINES];
	logic [63:0]      loaded_data     [1:`NUM_MEM_TAGS];
	logic [CNT_W-1:0] cycles_left     [1:`NUM_MEM_TAGS];
	logic             waiting_for_bus [1:`NUM_MEM_TAGS];

	logic [LINE_W-1:0] line;
	logic              valid_address;
	logic              acquire;
	logic [3:0]        acq_tag;
	logic [3:0]        bus_tag;
	logic [`NUM_MEM_TAGS:1] returned;

	// aligned and inside the array, else refused
	assign valid_address = (proc2mem_addr[2:0] == 3'b000) &&
		(proc2mem_addr < `MEM_SIZE_IN_BYTES);
	assign line = proc2mem_addr[LINE_W+2:3];

	////////////////////////////////////////////////////////////
	// tag selection
	////////////////////////////////////////////////////////////

	// walk downward so the lowest tag is picked last
	always_comb begin
		acq_tag = 4'd0;
		bus_tag = 4'd0;
		for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
			if (!waiting_for_bus[i] && cycles_left[i] == '0)
				acq_tag = 4'(i);
			if (waiting_for_bus[i] && cycles_left[i] == '0)
				bus_tag = 4'(i);
		end
	end

	assign acquire = ((proc2mem_command == bus_load) || (proc2mem_command == bus_store)) &&
		valid_address && (acq_tag != 4'd0);

	////////////////////////////////////////////////////////////
	// per-tag control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mem2proc_response <= 4'd0;
			mem2proc_tag      <= 4'd0;
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				cycles_left[i]     <= '0;
				waiting_for_bus[i] <= 1'b0;
			end
		end else begin
			mem2proc_response <= acquire ? acq_tag : 4'd0;
			mem2proc_tag      <= bus_tag;
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				if (cycles_left[i] != '0)
					cycles_left[i] <= cycles_left[i] - 1'b1;
			end
			// winner leaves the bus queue
			if (bus_tag != 4'd0)
				waiting_for_bus[bus_tag] <= 1'b0;
			// latency counts from the response
			if (acquire) begin
				cycles_left[acq_tag] <= CNT_W'(`MEM_LATENCY_IN_CYCLES);
				if (proc2mem_command == bus_load)
					waiting_for_bus[acq_tag] <= 1'b1;
			end
		end
	end

	// array and data path
	always_ff @(posedge clock) begin
		if (acquire) begin
			if (proc2mem_command == bus_load)
				loaded_data[acq_tag] <= unified_memory[line];
			else
				unified_memory[line] <= proc2mem_data;
		end
		if (bus_tag != 4'd0)
			mem2proc_data <= loaded_data[bus_tag];
	end

	// array powers up cleared
	initial begin
		for (int i = 0; i < `MEM_64BIT_LINES; i++)
			unified_memory[i] = 64'h0;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// tags seen on the bus since their last response
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			returned <= '0;
		end else begin
			if (mem2proc_response != 4'd0)
				returned[mem2proc_response] <= 1'b0;
			if (mem2proc_tag != 4'd0)
				returned[mem2proc_tag] <= 1'b1;
		end
	end

	a_tag_once: assert property (@(posedge clock) disable iff (!rst_n)
		(mem2proc_tag != 4'd0) |-> !returned[mem2proc_tag]);

endmodule

//--- mem_req_rx.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_req_rx (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              req_in_req,
	input  mem_pkg::mem_req_t req_in,
	output logic              req_in_ack,
	input  logic              req_pop,
	output mem_pkg::mem_req_t req_head,
	output logic              req_valid
);
	import mem_pkg::*;

	logic push;
	logic req_full;
	logic req_empty;

	// one push per handshake, held off while the queue is full
	assign push      = req_in_req && !req_in_ack && !req_full;
	assign req_valid = !req_empty;

	// ack rises with the push, falls after req drops
	always_ff @(posedge clock) begin
		if (!rst_n)
			req_in_ack <= 1'b0;
		else if (push)
			req_in_ack <= 1'b1;
		else if (!req_in_req)
			req_in_ack <= 1'b0;
	end

	mem_fifo #(.payload_t(mem_req_t), .DEPTH(`REQ_FIFO_DEPTH)) u_req_fifo (
		.clock(clock), .rst_n(rst_n),
		.push(push), .push_data(req_in),
		.pop(req_pop), .head(req_head),
		.empty(req_empty), .full(req_full), .count()
	);

endmodule

//--- mem_issue.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_issue (
	input  logic                  clock,
	input  logic                  rst_n,
	input  mem_pkg::mem_req_t     req_head,
	input  logic                  req_valid,
	output logic                  req_pop,
	output mem_pkg::bus_command_t proc2mem_command,
	output logic [63:0]           proc2mem_addr,
	output logic [63:0]           proc2mem_data,
	input  logic [3:0]            mem2proc_response,
	input  logic                  cpl_taken,
	output mem_pkg::mem_issue_t   issue
);
	import mem_pkg::*;

	localparam int CRED_W = $clog2(`CPL_FIFO_DEPTH + 1);

	typedef enum logic {s_drive, s_wait} issue_state_t;

	issue_state_t      state;
	logic [CRED_W-1:0] loads_out;
	logic [4:0]        refuse_cnt;
	logic              load_ok;
	logic              present;
	logic              accepted;
	logic              load_acc;

	// loads in flight or queued for the client
	assign load_ok  = loads_out < CRED_W'(`CPL_FIFO_DEPTH);
	assign present  = (state == s_drive) && req_valid && ((req_head.cmd != bus_load) || load_ok);
	assign accepted = (state == s_wait) && (mem2proc_response != 4'd0);
	assign load_acc = accepted && (req_head.cmd == bus_load);

	// head stays put until accepted, so a retry repeats it
	assign proc2mem_command = present ? req_head.cmd : bus_none;
	assign proc2mem_addr    = req_head.addr;
	assign proc2mem_data    = req_head.data;
	assign req_pop          = accepted;
	assign issue = '{valid: load_acc, tag: mem2proc_response, id: req_head.id};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state      <= s_drive;
			loads_out  <= '0;
			refuse_cnt <= 5'd0;
		end else begin
			// drive one cycle, then look at the response
			state <= (state == s_drive) ? (present ? s_wait : s_drive) : s_drive;
			case ({load_acc, cpl_taken})
				2'b10:   loads_out <= loads_out + 1'b1;
				2'b01:   loads_out <= loads_out - 1'b1;
				default: loads_out <= loads_out;
			endcase
			if (accepted)
				refuse_cnt <= 5'd0;
			else if (state == s_wait && refuse_cnt != 5'd31)
				refuse_cnt <= refuse_cnt + 1'b1;
		end
	end

	// a bad address is refused forever
	a_retry_bound: assert property (@(posedge clock) disable iff (!rst_n)
		refuse_cnt <= 5'd16);

endmodule

//--- mem_tag_table.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_tag_table (
	input  logic                clock,
	input  logic                rst_n,
	input  mem_pkg::mem_issue_t issue,
	input  logic [3:0]          mem2proc_tag,
	input  logic [63:0]         mem2proc_data,
	output logic                cpl_push,
	output mem_pkg::mem_cpl_t   cpl_data
);
	logic [7:0]             ids [1:`NUM_MEM_TAGS];
	logic [`NUM_MEM_TAGS:1] tag_valid;

	////////////////////////////////////////////////////////////
	// ownership bits and completion strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tag_valid <= '0;
			cpl_push  <= 1'b0;
		end else begin
			cpl_push <= (mem2proc_tag != 4'd0);
			// returning tag is free again
			if (mem2proc_tag != 4'd0)
				tag_valid[mem2proc_tag] <= 1'b0;
			if (issue.valid)
				tag_valid[issue.tag] <= 1'b1;
		end
	end

	// client id per tag, completion payload
	always_ff @(posedge clock) begin
		if (issue.valid)
			ids[issue.tag] <= issue.id;
		if (mem2proc_tag != 4'd0) begin
			cpl_data.id   <= ids[mem2proc_tag];
			cpl_data.data <= mem2proc_data;
		end
	end

	// memory returns only tags that were handed out for loads
	a_tag_known: assert property (@(posedge clock) disable iff (!rst_n)
		(mem2proc_tag != 4'd0) |-> tag_valid[mem2proc_tag]);

endmodule

//--- mem_cpl_tx.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_cpl_tx (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              cpl_push,
	input  mem_pkg::mem_cpl_t cpl_data,
	output logic              cpl_out_req,
	output mem_pkg::mem_cpl_t cpl_out,
	input  logic              cpl_out_ack,
	output logic              cpl_taken
);
	import mem_pkg::*;

	typedef enum logic [1:0] {tx_idle, tx_req, tx_ack_low} tx_state_t;

	tx_state_t state;
	mem_cpl_t  cpl_head;
	logic      cpl_empty;

	// pop frees a load credit
	assign cpl_taken   = (state == tx_idle) && !cpl_empty;
	assign cpl_out_req = (state == tx_req);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= tx_idle;
		end else begin
			case (state)
				tx_idle:    if (cpl_taken) state <= tx_req;
				tx_req:     if (cpl_out_ack) state <= tx_ack_low;
				default:    if (!cpl_out_ack) state <= tx_idle;
			endcase
		end
	end

	// held for the whole handshake
	always_ff @(posedge clock) begin
		if (cpl_taken)
			cpl_out <= cpl_head;
	end

	mem_fifo #(.payload_t(mem_cpl_t), .DEPTH(`CPL_FIFO_DEPTH)) u_cpl_fifo (
		.clock(clock), .rst_n(rst_n),
		.push(cpl_push), .push_data(cpl_data),
		.pop(cpl_taken), .head(cpl_head),
		.empty(cpl_empty), .full(), .count()
	);

endmodule

//--- mem_sys.sv
`timescale 1ns/10ps

module mem_sys (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              req_in_req,
	input  mem_pkg::mem_req_t req_in,
	output logic              req_in_ack,
	output logic              cpl_out_req,
	output mem_pkg::mem_cpl_t cpl_out,
	input  logic              cpl_out_ack
);
	import mem_pkg::*;

	// request queue to issue unit
	mem_req_t     req_head;
	logic         req_valid;
	logic         req_pop;

	// memory bus
	bus_command_t proc2mem_command;
	logic [63:0]  proc2mem_addr;
	logic [63:0]  proc2mem_data;
	logic [3:0]   mem2proc_response;
	logic [3:0]   mem2proc_tag;
	logic [63:0]  mem2proc_data;

	// load tracking and completions
	mem_issue_t   issue;
	logic         cpl_push;
	mem_cpl_t     cpl_data;
	logic         cpl_taken;

	mem_req_rx u_req_rx (
		.clock, .rst_n, .req_in_req, .req_in, .req_in_ack,
		.req_pop, .req_head, .req_valid
	);

	mem_issue u_issue (
		.clock, .rst_n, .req_head, .req_valid, .req_pop,
		.proc2mem_command, .proc2mem_addr, .proc2mem_data,
		.mem2proc_response, .cpl_taken, .issue
	);

	mem u_mem (
		.clock, .rst_n, .proc2mem_command, .proc2mem_addr, .proc2mem_data,
		.mem2proc_response, .mem2proc_tag, .mem2proc_data
	);

	mem_tag_table u_tag_table (
		.clock, .rst_n, .issue, .mem2proc_tag, .mem2proc_data, .cpl_push, .cpl_data
	);

	mem_cpl_tx u_cpl_tx (
		.clock, .rst_n, .cpl_push, .cpl_data,
		.cpl_out_req, .cpl_out, .cpl_out_ack, .cpl_taken
	);

endmodule

//--- tb_mem_sys.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module tb_mem_sys;
	import mem_pkg::*;

	localparam int          NUM_REQ        = 400;
	localparam int          TIMEOUT_CYCLES = NUM_REQ * 40;
	localparam int          DRAIN_LIMIT    = 2000;
	localparam int          DRAIN_CYCLES   = 50;
	localparam logic [31:0] SEED           = 32'h72a403c8;

	logic     clock;
	logic     rst_n;
	logic     req_in_req;
	mem_req_t req_in;
	logic     req_in_ack;
	logic     cpl_out_req;
	mem_cpl_t cpl_out;
	logic     cpl_out_ack;

	// reference memory and per-id expectations
	logic [63:0] model_mem [`MEM_64BIT_LINES];
	logic [63:0] exp_data  [256];
	logic        pending   [256];
	int          loads_sent;
	int          cpls_seen;
	int          cycle_count;
	logic        slow_acks;
	logic [31:0] stim_state;
	logic [31:0] ack_state;

	// previous-edge samples for the handshake monitor
	logic     req_prev;
	logic     ack_prev;
	logic     cpl_req_prev;
	mem_cpl_t cpl_prev;

	mem_sys DUT (
		.clock, .rst_n, .req_in_req, .req_in, .req_in_ack,
		.cpl_out_req, .cpl_out, .cpl_out_ack
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// numerical recipes constants
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	// full four-phase cycle on the request port
	task automatic send_req(input mem_req_t r);
		req_in     <= r;
		req_in_req <= 1'b1;
		do @(posedge clock); while (!req_in_ack);
		req_in_req <= 1'b0;
		do @(posedge clock); while (req_in_ack);
	endtask

	// one completion against the model
	task automatic check_cpl(input mem_cpl_t c);
		assert (pending[c.id]) else begin
			$display("completion for id %h that was never sent or already completed", c.id);
			abort_run();
		end
		assert (c.data == exp_data[c.id]) else begin
			$display("** Error: cpl_out.data (id %h) got %h, expected %h",
				c.id, c.data, exp_data[c.id]);
			abort_run();
		end
		pending[c.id] = 1'b0;
		cpls_seen++;
	endtask

	////////////////////////////////////////////////////////////
	// clock, watchdog, port monitor
	////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d loads completed",
				cycle_count, cpls_seen, loads_sent);
			abort_run();
		end
	end

	// values seen here are the ones from before the edge
	always @(posedge clock) begin
		if (rst_n) begin
			if (!req_in_ack && ack_prev)
				assert (!req_prev) else begin
					$display("req_in_ack dropped while req_in_req was still high");
					abort_run();
				end
			if (req_in_ack && !ack_prev)
				assert (req_prev) else begin
					$display("req_in_ack rose without a pending request");
					abort_run();
				end
			if (cpl_out_req && cpl_req_prev)
				assert (cpl_out == cpl_prev) else begin
					$display("** Error: cpl_out changed during handshake, was %h, now %h",
						cpl_prev, cpl_out);
					abort_run();
				end
		end
		req_prev     = req_in_req;
		ack_prev     = req_in_ack;
		cpl_req_prev = cpl_out_req;
		cpl_prev     = cpl_out;
	end

	////////////////////////////////////////////////////////////
	// completion client, random ack delay
	////////////////////////////////////////////////////////////

	initial begin : cpl_client
		int delay;
		wait (rst_n);
		forever begin
			@(posedge clock);
			if (cpl_out_req) begin
				check_cpl(cpl_out);
				ack_state = lcg_step(ack_state);
				// slow phase holds the ack off as long as allowed
				delay = slow_acks ? 12 : int'(ack_state[31:24] % 13);
				repeat (delay) @(posedge clock);
				cpl_out_ack <= 1'b1;
				do @(posedge clock); while (cpl_out_req);
				cpl_out_ack <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// reset and request stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		mem_req_t    req;
		logic [31:0] r;
		logic [63:0] last_addr;
		logic        last_store;
		logic [3:0]  load_thresh;
		logic        final_ok;
		int          line;

		// every input known before the first edge
		rst_n       = 1'b0;
		req_in_req  = 1'b0;
		req_in      = '0;
		cpl_out_ack = 1'b0;
		slow_acks   = 1'b0;
		stim_state  = SEED;
		ack_state   = SEED ^ 32'h5a5a5a5a;
		loads_sent  = 0;
		cpls_seen   = 0;
		cycle_count = 0;
		last_addr   = '0;
		last_store  = 1'b0;
		for (int i = 0; i < `MEM_64BIT_LINES; i++)
			model_mem[i] = 64'h0;
		for (int i = 0; i < 256; i++) begin
			pending[i]  = 1'b0;
			exp_data[i] = 64'h0;
		end

		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		assert (!req_in_ack && !cpl_out_req) else begin
			$display("** Error: after reset req_in_ack = %h, cpl_out_req = %h",
				req_in_ack, cpl_out_req);
			abort_run();
		end

		for (int n = 0; n < NUM_REQ; n++) begin
			// middle third is load heavy with slow acks
			slow_acks   = (n >= NUM_REQ / 3) && (n < 2 * NUM_REQ / 3);
			load_thresh = slow_acks ? 4'd13 : 4'd8;
			stim_state  = lcg_step(stim_state);
			r           = stim_state;
			// store then load to the same line now and then
			if (last_store && r[27:26] == 2'b00) begin
				req.cmd  = bus_load;
				req.addr = last_addr;
			end else begin
				req.cmd  = (r[31:28] < load_thresh) ? bus_load : bus_store;
				req.addr = 64'((r[25:10] % `MEM_64BIT_LINES) * 8);
			end
			req.id          = 8'(n);
			stim_state      = lcg_step(stim_state);
			req.data[63:32] = stim_state;
			stim_state      = lcg_step(stim_state);
			req.data[31:0]  = stim_state;

			// model follows request order
			line = int'(req.addr >> 3);
			if (req.cmd == bus_store) begin
				model_mem[line] = req.data;
			end else begin
				assert (!pending[req.id]) else begin
					$display("id %h reused while its load is still outstanding", req.id);
					abort_run();
				end
				exp_data[req.id] = model_mem[line];
				pending[req.id]  = 1'b1;
				loads_sent++;
			end
			last_addr  = req.addr;
			last_store = (req.cmd == bus_store);

			send_req(req);
			repeat (int'(r[9:8])) @(posedge clock);
		end
		slow_acks = 1'b0;

		// bounded wait for all loads, then nothing extra may show up
		for (int i = 0; i < DRAIN_LIMIT && cpls_seen != loads_sent; i++)
			@(posedge clock);
		repeat (DRAIN_CYCLES) @(posedge clock);
		final_ok = (cpls_seen == loads_sent);
		assert (final_ok) else
			$display("** Error: completions %h, loads sent %h", cpls_seen, loads_sent);
		if (final_ok) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- tb.f
+incdir+.
mem_pkg.sv
mem_fifo.sv
mem.sv
mem_req_rx.sv
mem_issue.sv
mem_tag_table.sv
mem_cpl_tx.sv
mem_sys.sv
tb_mem_sys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the verdict
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
